/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_top
FILELIST := bus_fabric_top.f
BUILD    := obj_dir
LOG      := sim.log

SIM_BIN  := $(BUILD)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bus_fabric_top.f */
+incdir+source
source/bus_pkg.sv
source/sram_pkg.sv
source/cpu_bus_if.sv
source/bus_decoder.sv
source/scratch_ram.sv
source/shared_sram.sv
source/bus_fabric_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/bus_fabric_assertions.sv
tests/tb_top.sv

/* source/bus_decoder.sv */
`timescale 1ns/1ps
`include "fabric_cfg.svh"

module bus_decoder (
  input  logic              sysclock,
  input  logic              rst_i,
  input  bus_pkg::addr_t    cpu_adr_i,
  input  bus_pkg::data_t    cpu_wdat_i,
  input  bus_pkg::sel_t     cpu_sel_i,
  input  logic              cpu_we_i,
  input  logic              cpu_cyc_i,
  output bus_pkg::data_t    cpu_rdat_o,
  output logic              cpu_ack_o,
  output logic              fault_o,
  input  bus_pkg::irq_t     io_irq_i,
  output bus_pkg::cpu_irq_t cpu_irq_o,
  cpu_bus_if.master         scr_bus,
  cpu_bus_if.master         sram_bus
);
  import bus_pkg::*;

  region_e region;
  logic    unmapped_cyc;
  logic    err_ack;

  // top nibble picks the region
  always_comb begin
    case (cpu_adr_i[`FABRIC_ADDR_W-1 -: `REGION_W])
      `REGION_SCRATCH: region = region_scratch;
      `REGION_SRAM:    region = region_sram;
      default:         region = region_unmapped;
    endcase
  end

  // address and data fan out, only cyc is steered
  assign scr_bus.adr   = cpu_adr_i;
  assign scr_bus.wdat  = cpu_wdat_i;
  assign scr_bus.sel   = cpu_sel_i;
  assign scr_bus.we    = cpu_we_i;
  assign scr_bus.cyc   = cpu_cyc_i && (region == region_scratch);

  assign sram_bus.adr  = cpu_adr_i;
  assign sram_bus.wdat = cpu_wdat_i;
  assign sram_bus.sel  = cpu_sel_i;
  assign sram_bus.we   = cpu_we_i;
  assign sram_bus.cyc  = cpu_cyc_i && (region == region_sram);

  assign unmapped_cyc = cpu_cyc_i && (region == region_unmapped);
  assign fault_o      = unmapped_cyc;

  // error ack one cycle after the fault, single pulse
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      err_ack <= 1'b0;
    end else begin
      err_ack <= unmapped_cyc && !err_ack;
    end
  end

  // response back to the cpu
  always_comb begin
    case (region)
      region_scratch: begin
        cpu_rdat_o = scr_bus.rdat;
        cpu_ack_o  = scr_bus.ack;
      end
      region_sram: begin
        cpu_rdat_o = sram_bus.rdat;
        cpu_ack_o  = sram_bus.ack;
      end
      default: begin
        cpu_rdat_o = '0;
        cpu_ack_o  = err_ack;
      end
    endcase
  end

  // interrupt hierarchy, a fault masks everything
  always_comb begin
    if (fault_o) begin
      cpu_irq_o = '0;
    end else if (|io_irq_i) begin
      cpu_irq_o = {1'b1, io_irq_i};
    end else begin
      cpu_irq_o = '0;
    end
  end

endmodule

/* source/bus_fabric_top.sv */
`timescale 1ns/1ps

module bus_fabric_top (
  input  logic              sysclock,
  input  logic              rst_i,
  input  bus_pkg::addr_t    cpu_adr_i,
  input  bus_pkg::data_t    cpu_wdat_i,
  input  bus_pkg::sel_t     cpu_sel_i,
  input  logic              cpu_we_i,
  input  logic              cpu_cyc_i,
  output bus_pkg::data_t    cpu_rdat_o,
  output logic              cpu_ack_o,
  output logic              fault_o,
  input  logic              vid_cyc_i,
  input  bus_pkg::addr_t    vid_adr_i,
  output bus_pkg::data_t    vid_dat_o,
  output logic              vid_ack_o,
  input  bus_pkg::irq_t     io_irq_i,
  output bus_pkg::cpu_irq_t cpu_irq_o
);

  // one decoded port per memory
  cpu_bus_if scr_bus ();
  cpu_bus_if sram_bus ();

  bus_decoder u_decoder (
    .sysclock   (sysclock),
    .rst_i      (rst_i),
    .cpu_adr_i  (cpu_adr_i),
    .cpu_wdat_i (cpu_wdat_i),
    .cpu_sel_i  (cpu_sel_i),
    .cpu_we_i   (cpu_we_i),
    .cpu_cyc_i  (cpu_cyc_i),
    .cpu_rdat_o (cpu_rdat_o),
    .cpu_ack_o  (cpu_ack_o),
    .fault_o    (fault_o),
    .io_irq_i   (io_irq_i),
    .cpu_irq_o  (cpu_irq_o),
    .scr_bus    (scr_bus.master),
    .sram_bus   (sram_bus.master)
  );

  scratch_ram u_scratch (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .bus      (scr_bus.slave)
  );

  // display master shares this one
  shared_sram u_sram (
    .sysclock  (sysclock),
    .rst_i     (rst_i),
    .bus       (sram_bus.slave),
    .vid_cyc_i (vid_cyc_i),
    .vid_adr_i (vid_adr_i),
    .vid_dat_o (vid_dat_o),
    .vid_ack_o (vid_ack_o)
  );

endmodule

/* source/bus_pkg.sv */
`include "fabric_cfg.svh"

package bus_pkg;

  // processor bus vectors
  typedef logic [`FABRIC_ADDR_W-1:0]   addr_t;
  typedef logic [`FABRIC_DATA_W-1:0]   data_t;
  typedef logic [`FABRIC_DATA_W/8-1:0] sel_t;

  // two peripheral lines in, three-bit vector to the cpu
  typedef logic [1:0] irq_t;
  typedef logic [2:0] cpu_irq_t;

  // decoded target of a processor cycle
  typedef enum logic [1:0] {
    region_scratch,
    region_sram,
    region_unmapped
  } region_e;

endpackage

/* source/cpu_bus_if.sv */
`timescale 1ns/1ps

interface cpu_bus_if;
  import bus_pkg::*;

  addr_t adr;
  data_t wdat;
  sel_t  sel;
  logic  we;
  logic  cyc;
  data_t rdat;
  logic  ack;

  // decoder side
  modport master (
    output adr,
    output wdat,
    output sel,
    output we,
    output cyc,
    input  rdat,
    input  ack
  );

  // memory side
  modport slave (
    input  adr,
    input  wdat,
    input  sel,
    input  we,
    input  cyc,
    output rdat,
    output ack
  );

endinterface

/* source/fabric_cfg.svh */
`ifndef FABRIC_CFG_SVH
`define FABRIC_CFG_SVH

// processor bus widths
`define FABRIC_ADDR_W 32
`define FABRIC_DATA_W 32

// region code sits in the top address nibble
`define REGION_W       4
`define REGION_SCRATCH 4'h0
`define REGION_SRAM    4'hC

// word-address bits and depth of each memory
`define SCRATCH_AW    8
`define SCRATCH_WORDS (1 << `SCRATCH_AW)
`define SRAM_AW       10
`define SRAM_WORDS    (1 << `SRAM_AW)

`endif

/* source/scratch_ram.sv */
`timescale 1ns/1ps
`include "fabric_cfg.svh"

module scratch_ram (
  input  logic     sysclock,
  input  logic     rst_i,
  cpu_bus_if.slave bus
);
  import bus_pkg::*;

  data_t                  mem [`SCRATCH_WORDS];
  logic [`SCRATCH_AW-1:0] idx;
  logic [1:0]             ack_sr;
  logic                   access;
  data_t                  rd_q;

  initial begin
    for (int i = 0; i < `SCRATCH_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // word index above the byte offset
  assign idx = bus.adr[`SCRATCH_AW+1:2];

  // second pipeline stage is where the word is touched
  assign access = bus.cyc && ack_sr[0] && !ack_sr[1];

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_sr <= 2'b00;
    end else if (!bus.cyc || ack_sr[1]) begin
      ack_sr <= 2'b00;
    end else begin
      ack_sr <= {ack_sr[0], 1'b1};
    end
  end

  // byte-lane writes
  always @(posedge sysclock) begin
    if (access && bus.we) begin
      for (int b = 0; b < `FABRIC_DATA_W/8; b++) begin
        if (bus.sel[b]) begin
          mem[idx][8*b +: 8] <= bus.wdat[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge sysclock) begin
    if (access) begin
      rd_q <= mem[idx];
    end
  end

  assign bus.rdat = rd_q;
  assign bus.ack  = ack_sr[1];

endmodule

/* source/shared_sram.sv */
`timescale 1ns/1ps
`include "fabric_cfg.svh"

module shared_sram (
  input  logic           sysclock,
  input  logic           rst_i,
  cpu_bus_if.slave       bus,
  input  logic           vid_cyc_i,
  input  bus_pkg::addr_t vid_adr_i,
  output bus_pkg::data_t vid_dat_o,
  output logic           vid_ack_o
);
  import bus_pkg::*;
  import sram_pkg::*;

  arb_state_e state;
  logic       cpu_req;
  logic       vid_req;
  logic       cpu_first;
  logic       cpu_ack_q;
  logic       vid_ack_q;
  sram_addr_t cpu_idx;
  sram_addr_t vid_idx;
  sram_addr_t mem_idx;
  logic       mem_we;
  data_t      mem [`SRAM_WORDS];
  data_t      rd_q;

  initial begin
    for (int i = 0; i < `SRAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // a master whose ack is still showing has finished, ignore it
  assign cpu_req = bus.cyc && !cpu_ack_q;
  assign vid_req = vid_cyc_i && !vid_ack_q;

  assign cpu_idx = bus.adr[`SRAM_AW+1:2];
  assign vid_idx = vid_adr_i[`SRAM_AW+1:2];

  // granted master drives the memory
  assign mem_idx = (state == arb_vid_grant) ? vid_idx : cpu_idx;
  assign mem_we  = (state == arb_cpu_grant) && bus.we;

  // display wins a tie unless the cpu already waited once
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      state     <= arb_idle;
      cpu_first <= 1'b0;
      cpu_ack_q <= 1'b0;
      vid_ack_q <= 1'b0;
    end else begin
      cpu_ack_q <= (state == arb_cpu_grant);
      vid_ack_q <= (state == arb_vid_grant);
      case (state)
        arb_idle: begin
          if (cpu_req && (cpu_first || !vid_req)) begin
            state     <= arb_cpu_grant;
            cpu_first <= 1'b0;
          end else if (vid_req) begin
            state <= arb_vid_grant;
          end
        end
        arb_vid_grant: begin
          state <= arb_idle;
          if (cpu_req) begin
            cpu_first <= 1'b1;
          end
        end
        default: begin
          state <= arb_idle;
        end
      endcase
    end
  end

  // only the cpu writes, per byte lane
  always @(posedge sysclock) begin
    if (mem_we) begin
      for (int b = 0; b < `FABRIC_DATA_W/8; b++) begin
        if (bus.sel[b]) begin
          mem[mem_idx][8*b +: 8] <= bus.wdat[8*b +: 8];
        end
      end
    end
  end

  // one read register serves both masters
  always_ff @(posedge sysclock) begin
    if (state != arb_idle) begin
      rd_q <= mem[mem_idx];
    end
  end

  assign bus.rdat  = rd_q;
  assign bus.ack   = cpu_ack_q;
  assign vid_dat_o = rd_q;
  assign vid_ack_o = vid_ack_q;

endmodule

/* source/sram_pkg.sv */
`include "fabric_cfg.svh"

package sram_pkg;

  // word index into the shared memory
  typedef logic [`SRAM_AW-1:0] sram_addr_t;

  // who owns the shared memory this cycle
  typedef enum logic [1:0] {
    arb_idle,
    arb_cpu_grant,
    arb_vid_grant
  } arb_state_e;

endpackage

/* tests/bus_fabric_assertions.sv */
`timescale 1ns/1ps

module bus_fabric_assertions #(
  parameter bit CHECK_GRANT = 1'b0
) (
  input logic sysclock,
  input logic rst_i,
  input logic cyc_i,
  input logic ack_i,
  input logic other_ack_i
);

  // acks last exactly one cycle
  ack_pulse: assert property (@(posedge sysclock) disable iff (rst_i) ack_i |=> !ack_i)
    else $error("ack held for more than one cycle");

  ack_has_cyc: assert property (@(posedge sysclock) disable iff (rst_i) ack_i |-> cyc_i)
    else $error("ack seen without a pending cycle");

  // access windows of the two masters never touch, so one grant at a time
  if (CHECK_GRANT) begin : g_grant
    one_grant: assert property (@(posedge sysclock) disable iff (rst_i)
      !(ack_i && (other_ack_i || $past(other_ack_i))) && !(other_ack_i && $past(ack_i)))
      else $error("both masters granted at once");
  end

endmodule

bind bus_decoder bus_fabric_assertions u_cpu_checks (
  .sysclock    (sysclock),
  .rst_i       (rst_i),
  .cyc_i       (cpu_cyc_i),
  .ack_i       (cpu_ack_o),
  .other_ack_i (1'b0)
);

bind shared_sram bus_fabric_assertions #(
  .CHECK_GRANT (1'b1)
) u_arb_checks (
  .sysclock    (sysclock),
  .rst_i       (rst_i),
  .cyc_i       (vid_cyc_i),
  .ack_i       (vid_ack_o),
  .other_ack_i (cpu_ack_q)
);

/* tests/tb_checker.sv */
`timescale 1ns/1ps
`include "fabric_cfg.svh"

module tb_checker (
  input  logic              sysclock,
  input  logic              rst_i,
  input  bus_pkg::addr_t    cpu_adr_i,
  input  bus_pkg::data_t    cpu_wdat_i,
  input  bus_pkg::sel_t     cpu_sel_i,
  input  logic              cpu_we_i,
  input  logic              cpu_cyc_i,
  input  bus_pkg::data_t    cpu_rdat_i,
  input  logic              cpu_ack_i,
  input  logic              fault_i,
  input  logic              vid_cyc_i,
  input  bus_pkg::addr_t    vid_adr_i,
  input  bus_pkg::data_t    vid_dat_i,
  input  logic              vid_ack_i,
  input  bus_pkg::irq_t     io_irq_i,
  input  bus_pkg::cpu_irq_t cpu_irq_i,
  output int                err_count_o,
  output int                cpu_acks_o,
  output int                vid_acks_o
);
  import bus_pkg::*;

  data_t    scr_model  [`SCRATCH_WORDS];
  data_t    sram_model [`SRAM_WORDS];
  int       cpu_wait;
  logic     cpu_busy;
  logic     cpu_acked;
  logic     vid_acked;
  region_e  cur_region;
  logic     exp_fault;
  cpu_irq_t exp_irq;

  // top nibble 0 is scratch, C is shared memory, the rest is a hole
  function automatic region_e region_of(addr_t adr);
    logic [`REGION_W-1:0] code;
    code = adr[`FABRIC_ADDR_W-1 -: `REGION_W];
    if (code == `REGION_SCRATCH) begin
      return region_scratch;
    end else if (code == `REGION_SRAM) begin
      return region_sram;
    end
    return region_unmapped;
  endfunction

  function automatic data_t merge_bytes(data_t old, data_t wdat, sel_t sel);
    data_t res;
    res = old;
    for (int b = 0; b < `FABRIC_DATA_W/8; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = wdat[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_mismatch(string msg);
    $display("FAIL %0t: %s", $time, msg);
    err_count_o++;
  endtask

  // processor response at the ack, checked against the models
  task automatic check_cpu_response();
    logic [`SCRATCH_AW-1:0] scr_idx;
    logic [`SRAM_AW-1:0]    sram_idx;
    scr_idx  = cpu_adr_i[`SCRATCH_AW+1:2];
    sram_idx = cpu_adr_i[`SRAM_AW+1:2];
    cpu_acks_o++;
    case (cur_region)
      region_scratch: begin
        if (cpu_wait != 2) begin
          report_mismatch($sformatf("scratch ack after %0d cycles, expected 2", cpu_wait));
        end
        if (cpu_we_i) begin
          scr_model[scr_idx] = merge_bytes(scr_model[scr_idx], cpu_wdat_i, cpu_sel_i);
        end else if (cpu_rdat_i !== scr_model[scr_idx]) begin
          report_mismatch($sformatf("scratch read %h gave %h, expected %h",
                                    cpu_adr_i, cpu_rdat_i, scr_model[scr_idx]));
        end
      end
      region_sram: begin
        if (cpu_we_i) begin
          sram_model[sram_idx] = merge_bytes(sram_model[sram_idx], cpu_wdat_i, cpu_sel_i);
        end else if (cpu_rdat_i !== sram_model[sram_idx]) begin
          report_mismatch($sformatf("shared read %h gave %h, expected %h",
                                    cpu_adr_i, cpu_rdat_i, sram_model[sram_idx]));
        end
      end
      default: begin
        if (cpu_wait != 1) begin
          report_mismatch($sformatf("error ack after %0d cycles, expected 1", cpu_wait));
        end
        if (cpu_rdat_i !== '0) begin
          report_mismatch($sformatf("unmapped read %h gave %h, expected 0",
                                    cpu_adr_i, cpu_rdat_i));
        end
      end
    endcase
  endtask

  always @(negedge sysclock) begin
    if (rst_i) begin
      for (int i = 0; i < `SCRATCH_WORDS; i++) begin
        scr_model[i] = '0;
      end
      for (int i = 0; i < `SRAM_WORDS; i++) begin
        sram_model[i] = '0;
      end
      err_count_o = 0;
      cpu_acks_o  = 0;
      vid_acks_o  = 0;
      cpu_wait    = 0;
      cpu_busy    = 1'b0;
      cpu_acked   = 1'b0;
      vid_acked   = 1'b0;
    end else begin
      cur_region = region_of(cpu_adr_i);
      exp_fault  = cpu_cyc_i && (cur_region == region_unmapped);
      if (fault_i !== exp_fault) begin
        report_mismatch($sformatf("fault_o is %b, expected %b", fault_i, exp_fault));
      end
      exp_irq = (!exp_fault && (|io_irq_i)) ? {1'b1, io_irq_i} : '0;
      if (cpu_irq_i !== exp_irq) begin
        report_mismatch($sformatf("cpu_irq_o is %b, expected %b", cpu_irq_i, exp_irq));
      end

      // cycles since cyc was first seen
      if (!cpu_cyc_i) begin
        cpu_busy  = 1'b0;
        cpu_acked = 1'b0;
        cpu_wait  = 0;
      end else if (!cpu_busy) begin
        cpu_busy = 1'b1;
        cpu_wait = 0;
      end else begin
        cpu_wait++;
      end
      if (cpu_ack_i) begin
        if (!cpu_cyc_i || cpu_acked) begin
          report_mismatch("processor ack without a pending cycle");
        end else begin
          check_cpu_response();
        end
        cpu_acked = 1'b1;
      end

      if (!vid_cyc_i) begin
        vid_acked = 1'b0;
      end
      if (vid_ack_i) begin
        if (!vid_cyc_i || vid_acked) begin
          report_mismatch("display ack without a pending request");
        end else begin
          vid_acks_o++;
          if (vid_dat_i !== sram_model[vid_adr_i[`SRAM_AW+1:2]]) begin
            report_mismatch($sformatf("display read %h gave %h, expected %h", vid_adr_i,
                                      vid_dat_i, sram_model[vid_adr_i[`SRAM_AW+1:2]]));
          end
        end
        vid_acked = 1'b1;
      end
    end
  end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic sysclock
);

  // 10 ns period
  initial begin
    sysclock = 1'b0;
    forever #5 sysclock = ~sysclock;
  end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps
`include "fabric_cfg.svh"

module tb_top;
  import bus_pkg::*;

  localparam int NUM_TXN     = 600;
  localparam int POOL_WORDS  = 64;
  localparam int RESET_CYC   = 16;
  localparam int WATCHDOG_NS = NUM_TXN * 20 * 10;

  logic     sysclock;
  logic     rst_i;
  addr_t    cpu_adr;
  data_t    cpu_wdat;
  sel_t     cpu_sel;
  logic     cpu_we;
  logic     cpu_cyc;
  data_t    cpu_rdat;
  logic     cpu_ack;
  logic     fault;
  logic     vid_cyc;
  addr_t    vid_adr;
  data_t    vid_dat;
  logic     vid_ack;
  irq_t     io_irq;
  cpu_irq_t cpu_irq;
  logic     cpu_done;
  int       err_count;
  int       cpu_acks;
  int       vid_acks;

  tb_clock u_clock (
    .sysclock (sysclock)
  );

  bus_fabric_top dut (
    .sysclock   (sysclock),
    .rst_i      (rst_i),
    .cpu_adr_i  (cpu_adr),
    .cpu_wdat_i (cpu_wdat),
    .cpu_sel_i  (cpu_sel),
    .cpu_we_i   (cpu_we),
    .cpu_cyc_i  (cpu_cyc),
    .cpu_rdat_o (cpu_rdat),
    .cpu_ack_o  (cpu_ack),
    .fault_o    (fault),
    .vid_cyc_i  (vid_cyc),
    .vid_adr_i  (vid_adr),
    .vid_dat_o  (vid_dat),
    .vid_ack_o  (vid_ack),
    .io_irq_i   (io_irq),
    .cpu_irq_o  (cpu_irq)
  );

  tb_checker u_checker (
    .sysclock    (sysclock),
    .rst_i       (rst_i),
    .cpu_adr_i   (cpu_adr),
    .cpu_wdat_i  (cpu_wdat),
    .cpu_sel_i   (cpu_sel),
    .cpu_we_i    (cpu_we),
    .cpu_cyc_i   (cpu_cyc),
    .cpu_rdat_i  (cpu_rdat),
    .cpu_ack_i   (cpu_ack),
    .fault_i     (fault),
    .vid_cyc_i   (vid_cyc),
    .vid_adr_i   (vid_adr),
    .vid_dat_i   (vid_dat),
    .vid_ack_i   (vid_ack),
    .io_irq_i    (io_irq),
    .cpu_irq_i   (cpu_irq),
    .err_count_o (err_count),
    .cpu_acks_o  (cpu_acks),
    .vid_acks_o  (vid_acks)
  );

  // 64 shared words spread over the memory, both masters use them
  function automatic addr_t pool_addr(logic [5:0] p);
    return {`REGION_SRAM, 16'h0, p, 4'h9, 2'b00};
  endfunction

  // one processor cycle, entered and left 1 ns after a rising edge
  task automatic run_cpu_txn();
    int                   pick;
    logic [`REGION_W-1:0] code;
    pick = $urandom_range(0, 99);
    if (pick < 45) begin
      cpu_adr = {`REGION_SCRATCH, 18'h0, 8'($urandom_range(0, 255)), 2'b00};
    end else if (pick < 90) begin
      cpu_adr = pool_addr(6'($urandom_range(0, POOL_WORDS-1)));
    end else begin
      code = 4'($urandom_range(1, 14));
      if (code == `REGION_SRAM) begin
        code = 4'h5;
      end
      cpu_adr = {code, 26'($urandom), 2'b00};
    end
    cpu_we   = ($urandom_range(0, 1) == 1);
    cpu_sel  = sel_t'($urandom_range(1, 15));
    cpu_wdat = $urandom;
    cpu_cyc  = 1'b1;
    @(negedge sysclock);
    while (!cpu_ack) begin
      @(negedge sysclock);
    end
    @(posedge sysclock);
    #1;
    cpu_cyc = 1'b0;
    repeat ($urandom_range(1, 3)) @(posedge sysclock);
    #1;
  endtask

  // display reads run beside the processor until it is done
  task automatic run_display();
    while (!cpu_done) begin
      vid_adr = pool_addr(6'($urandom_range(0, POOL_WORDS-1)));
      vid_cyc = 1'b1;
      @(negedge sysclock);
      while (!vid_ack) begin
        @(negedge sysclock);
      end
      @(posedge sysclock);
      #1;
      vid_cyc = 1'b0;
      repeat ($urandom_range(1, 6)) @(posedge sysclock);
      #1;
    end
  endtask

  initial begin
    void'($urandom(81));
    rst_i    = 1'b1;
    cpu_adr  = '0;
    cpu_wdat = '0;
    cpu_sel  = '0;
    cpu_we   = 1'b0;
    cpu_cyc  = 1'b0;
    vid_cyc  = 1'b0;
    vid_adr  = '0;
    io_irq   = '0;
    cpu_done = 1'b0;
    repeat (RESET_CYC) @(posedge sysclock);
    #1;
    rst_i = 1'b0;
    @(posedge sysclock);
    #1;
    fork
      begin
        for (int n = 0; n < NUM_TXN; n++) begin
          run_cpu_txn();
        end
        cpu_done = 1'b1;
      end
      run_display();
    join
    repeat (4) @(posedge sysclock);
    $display("done: %0d cpu acks, %0d display acks, %0d errors", cpu_acks, vid_acks,
             err_count);
    if (cpu_acks != NUM_TXN) begin
      $display("expected %0d processor acks but counted %0d", NUM_TXN, cpu_acks);
    end
    if (err_count == 0 && cpu_acks == NUM_TXN) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // peripheral interrupt lines wander every few cycles
  initial begin
    @(negedge rst_i);
    forever begin
      repeat ($urandom_range(2, 7)) @(posedge sysclock);
      #1;
      io_irq = irq_t'($urandom_range(0, 3));
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
